//--- vlog.f
rr_pkg.sv
rr_csrs.sv
rr_trace_meter.sv
rr_top.sv
rr_assertions.sv
tb_rr.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_rr -f vlog.f -o tb_rr
./obj_dir/tb_rr > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    exit 1
fi
exit 0

//--- tb_rr.sv
`default_nettype none

module tb_rr;

    localparam int num_tests = 5;

    logic clk;
    logic rstn;
    rr_pkg::rr_axil_req_t      cfg_req;
    rr_pkg::rr_axil_rsp_t      cfg_rsp;
    logic                      record_valid;
    rr_pkg::rr_record_beat_t   record_data;
    logic                      record_ready;
    logic                      validate_valid;
    rr_pkg::rr_validate_beat_t validate_data;
    logic                      validate_ready;

    logic [31:0] lfsr;
    int          err_cnt;
    int          test_err_base;

    // Reference model state
    logic [31:0] model_regs [16];
    logic [63:0] rec_cnt;
    logic [63:0] val_cnt;
    int          rec_acc;
    int          val_acc;
    int          rec_offered;

    rr_top u_dut (
        .clk            (clk),
        .rstn           (rstn),
        .cfg_req        (cfg_req),
        .cfg_rsp        (cfg_rsp),
        .record_valid   (record_valid),
        .record_data    (record_data),
        .record_ready   (record_ready),
        .validate_valid (validate_valid),
        .validate_data  (validate_data),
        .validate_ready (validate_ready)
    );

    bind rr_top rr_assertions u_assertions (
        .clk           (clk),
        .rstn          (rstn),
        .cfg_req       (cfg_req),
        .cfg_rsp       (cfg_rsp),
        .mode_csr      (mode_csr),
        .storage_csr   (storage_csr),
        .record_bits   (record_bits),
        .validate_bits (validate_bits)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(4000 * num_tests * 40);
        $display("timeout: the tests did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("error %s exp %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    function automatic logic [31:0] model_read(input int idx);
        case (idx)
            5: return rec_cnt[31:0];
            6: return rec_cnt[63:32];
            7: return val_cnt[31:0];
            8: return val_cnt[63:32];
            default: return model_regs[idx];
        endcase
    endfunction

    function automatic logic [63:0] model_buf_size();
        return {model_regs[2], model_regs[1]};
    endfunction

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s done, %0d errors", num, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    task automatic axil_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
        int  d_aw;
        int  d_w;
        int  cyc;
        bit  aw_done;
        bit  w_done;
        bit  aw_fire;
        bit  w_fire;
        bit  b_done;
        logic [31:0] mask;
        d_aw = int'(rand_bits(2));
        d_w = int'(rand_bits(2));
        aw_done = 1'b0;
        w_done = 1'b0;
        cyc = 0;
        cfg_req.awaddr = 32'(idx) << 2;
        cfg_req.wdata = data;
        cfg_req.wstrb = strb;
        // Address and data start at independent random delays
        while (!(aw_done && w_done)) begin
            cfg_req.awvalid = !aw_done && (cyc >= d_aw);
            cfg_req.wvalid = !w_done && (cyc >= d_w);
            @(negedge clk);
            aw_fire = cfg_req.awvalid && cfg_rsp.awready;
            w_fire = cfg_req.wvalid && cfg_rsp.wready;
            @(posedge clk);
            #1;
            aw_done = aw_done || aw_fire;
            w_done = w_done || w_fire;
            cyc++;
        end
        cfg_req.awvalid = 1'b0;
        cfg_req.wvalid = 1'b0;
        b_done = 1'b0;
        while (!b_done) begin
            cfg_req.bready = rand_bits(1) != 0;
            @(negedge clk);
            if (cfg_rsp.bvalid && cfg_req.bready) begin
                compare("bresp", 32'(rr_pkg::rr_resp_okay), 32'(cfg_rsp.bresp));
                b_done = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        cfg_req.bready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        if (idx == 3) begin
            rec_cnt = '0;
        end else if (idx == 4) begin
            val_cnt = '0;
        end else if (idx < 5 || idx > 8) begin
            model_regs[idx] = (data & mask) | (model_regs[idx] & ~mask);
        end
    endtask

    task automatic read_check(input int idx, input string name);
        bit ar_done;
        bit r_done;
        ar_done = 1'b0;
        r_done = 1'b0;
        cfg_req.araddr = 32'(idx) << 2;
        cfg_req.arvalid = 1'b1;
        while (!ar_done) begin
            @(negedge clk);
            ar_done = cfg_rsp.arready;
            @(posedge clk);
            #1;
        end
        cfg_req.arvalid = 1'b0;
        while (!r_done) begin
            cfg_req.rready = rand_bits(1) != 0;
            @(negedge clk);
            if (cfg_rsp.rvalid && cfg_req.rready) begin
                compare(name, model_read(idx), cfg_rsp.rdata);
                compare("rresp", 32'(rr_pkg::rr_resp_okay), 32'(cfg_rsp.rresp));
                r_done = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        cfg_req.rready = 1'b0;
    endtask

    // Beats are held until accepted, then dropped when the run ends
    task automatic run_streams(input int cycles, input bit rec_on, input bit val_on);
        bit rec_exp;
        bit val_exp;
        bit rec_fire;
        bit val_fire;
        bit rec_hs;
        bit val_hs;
        for (int c = 0; c < cycles; c++) begin
            if (!record_valid) begin
                record_valid = rec_on && (rand_bits(1) != 0);
                record_data.tag = 16'(rand_bits(16));
                record_data.value = rand_bits(32);
                if (record_valid) begin
                    rec_offered++;
                end
            end
            if (!validate_valid) begin
                validate_valid = val_on && (rand_bits(1) != 0);
                validate_data.value = rand_bits(32);
            end
            @(negedge clk);
            rec_exp = model_regs[0][0] && (rec_cnt + 64'd48 <= model_buf_size());
            val_exp = model_regs[0][1] && (val_cnt + 64'd32 <= model_buf_size());
            compare("record_ready", 32'(rec_exp), 32'(record_ready));
            compare("validate_ready", 32'(val_exp), 32'(validate_ready));
            rec_fire = record_valid && rec_exp;
            val_fire = validate_valid && val_exp;
            // Transfers seen on the DUT handshake
            rec_hs = record_valid && record_ready;
            val_hs = validate_valid && validate_ready;
            @(posedge clk);
            #1;
            if (rec_fire) begin
                rec_cnt = rec_cnt + 64'd48;
            end
            if (rec_hs) begin
                rec_acc++;
                record_valid = 1'b0;
            end
            if (val_fire) begin
                val_cnt = val_cnt + 64'd32;
            end
            if (val_hs) begin
                val_acc++;
                validate_valid = 1'b0;
            end
        end
        record_valid = 1'b0;
        validate_valid = 1'b0;
    endtask

    task automatic read_counts();
        read_check(5, "record_bits_lo");
        read_check(6, "record_bits_hi");
        read_check(7, "validate_bits_lo");
        read_check(8, "validate_bits_hi");
    endtask

    initial begin
        int idx;
        int exp_acc;
        lfsr = 32'heb6a;
        err_cnt = 0;
        test_err_base = 0;
        rec_cnt = '0;
        val_cnt = '0;
        rec_acc = 0;
        val_acc = 0;
        rec_offered = 0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        rstn = 1'b0;
        cfg_req = '0;
        record_valid = 1'b0;
        record_data = '0;
        validate_valid = 1'b0;
        validate_data = '0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Full word writes to scratch and size registers
        for (int n = 0; n < 20; n++) begin
            idx = int'(rand_bits(4));
            if (idx < 9 && idx != 1 && idx != 2) begin
                idx = 9 + idx % 7;
            end
            axil_write(idx, rand_bits(32), 4'hf);
            read_check(idx, "rdata");
        end
        finish_test(1, "full word write and read");

        for (int n = 0; n < 16; n++) begin
            idx = 9 + int'(rand_bits(3)) % 7;
            axil_write(idx, rand_bits(32), 4'(rand_bits(4)));
            read_check(idx, "rdata");
        end
        for (int i = 5; i <= 8; i++) begin
            axil_write(i, rand_bits(32), 4'hf);
            read_check(i, "counter rdata");
        end
        finish_test(2, "partial strobes and read-only counters");

        axil_write(3, '0, 4'hf);
        axil_write(2, '0, 4'hf);
        axil_write(1, 32'(rand_bits(10)), 4'hf);
        axil_write(0, 32'd1, 4'hf);
        rec_acc = 0;
        rec_offered = 0;
        run_streams(60, 1'b1, 1'b0);
        exp_acc = int'(model_buf_size() / 64'd48);
        if (rec_offered < exp_acc) begin
            exp_acc = rec_offered;
        end
        compare("record beats accepted", 32'(exp_acc), 32'(rec_acc));
        read_counts();
        finish_test(3, "record stream and back-pressure");

        axil_write(4, '0, 4'hf);
        axil_write(1, 32'(rand_bits(11)), 4'hf);
        val_acc = 0;
        for (int n = 0; n < 6; n++) begin
            axil_write(0, {30'd0, rand_bits(1) != 0, 1'b1}, 4'hf);
            run_streams(16, 1'b1, 1'b1);
        end
        compare("validate beats accepted", 32'(val_cnt / 64'd32), 32'(val_acc));
        read_counts();
        finish_test(4, "validate stream with enable toggling");

        axil_write(1, 32'd2000, 4'hf);
        axil_write(0, 32'd3, 4'hf);
        run_streams(20, 1'b1, 1'b1);
        axil_write(3, rand_bits(32), 4'hf);
        read_counts();
        run_streams(20, 1'b1, 1'b1);
        axil_write(4, rand_bits(32), 4'hf);
        read_counts();
        finish_test(5, "buffer update commands");

        $display("tests %0d errors %0d", num_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rr_assertions.sv
`default_nettype none

module rr_assertions (
    input wire logic                    clk,
    input wire logic                    rstn,
    input wire rr_pkg::rr_axil_req_t    cfg_req,
    input wire rr_pkg::rr_axil_rsp_t    cfg_rsp,
    input wire rr_pkg::rr_mode_csr_t    mode_csr,
    input wire rr_pkg::rr_storage_csr_t storage_csr,
    input wire logic [63:0]             record_bits,
    input wire logic [63:0]             validate_bits
);

    // Synchronous reset clears both response valids on the next edge
    assert property (@(posedge clk) !rstn |=> !cfg_rsp.bvalid && !cfg_rsp.rvalid)
        else $error("response valid high during reset");

    assert property (@(posedge clk) disable iff (!rstn)
        cfg_rsp.bvalid && !cfg_req.bready |=> cfg_rsp.bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (!rstn)
        cfg_rsp.rvalid && !cfg_req.rready |=> cfg_rsp.rvalid && $stable(cfg_rsp.rdata))
        else $error("read data changed while waiting for rready");

    // A disabled meter takes no beat, so its count holds unless cleared
    assert property (@(posedge clk) disable iff (!rstn)
        !mode_csr.record_en && !storage_csr.record_buf_update |=> $stable(record_bits))
        else $error("record count moved while disabled");

    assert property (@(posedge clk) disable iff (!rstn)
        !mode_csr.validate_en && !storage_csr.validate_buf_update |=> $stable(validate_bits))
        else $error("validate count moved while disabled");

endmodule

`default_nettype wire

//--- rr_top.sv
`default_nettype none

module rr_top (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire rr_pkg::rr_axil_req_t      cfg_req,
    output rr_pkg::rr_axil_rsp_t           cfg_rsp,
    input  wire logic                      record_valid,
    input  wire rr_pkg::rr_record_beat_t   record_data,
    output logic                           record_ready,
    input  wire logic                      validate_valid,
    input  wire rr_pkg::rr_validate_beat_t validate_data,
    output logic                           validate_ready
);

    rr_pkg::rr_storage_csr_t storage_csr;
    rr_pkg::rr_mode_csr_t    mode_csr;
    rr_pkg::rr_counter_csr_t counter_csr;

    logic [63:0] record_bits;
    logic [63:0] validate_bits;

    rr_csrs u_csrs (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_req     (cfg_req),
        .cfg_rsp     (cfg_rsp),
        .storage_csr (storage_csr),
        .mode_csr    (mode_csr),
        .counter_csr (counter_csr)
    );

    // Record stream, 48 bit beats
    rr_trace_meter #(
        .payload_t (rr_pkg::rr_record_beat_t)
    ) u_record_meter (
        .clk      (clk),
        .rstn     (rstn),
        .en       (mode_csr.record_en),
        .limit    (storage_csr.buf_size),
        .clear    (storage_csr.record_buf_update),
        .in_valid (record_valid),
        .in_data  (record_data),
        .in_ready (record_ready),
        .bits     (record_bits)
    );

    // Validate stream, 32 bit beats
    rr_trace_meter #(
        .payload_t (rr_pkg::rr_validate_beat_t)
    ) u_validate_meter (
        .clk      (clk),
        .rstn     (rstn),
        .en       (mode_csr.validate_en),
        .limit    (storage_csr.buf_size),
        .clear    (storage_csr.validate_buf_update),
        .in_valid (validate_valid),
        .in_data  (validate_data),
        .in_ready (validate_ready),
        .bits     (validate_bits)
    );

    assign counter_csr = '{
        record_bits:   record_bits,
        validate_bits: validate_bits
    };

endmodule

`default_nettype wire

//--- rr_trace_meter.sv
`default_nettype none

module rr_trace_meter #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        en,
    input  wire logic [63:0] limit,
    input  wire logic        clear,
    input  wire logic        in_valid,
    input  wire payload_t    in_data,
    output logic             in_ready,
    output logic [63:0]      bits
);

    // Each accepted beat adds the full payload width
    localparam int unsigned beat_bits = $bits(in_data);

    logic [63:0] count;
    logic [64:0] count_next;
    logic        fire;

    // One extra bit so a limit near the top cannot wrap the compare
    assign count_next = {1'b0, count} + 65'(beat_bits);

    // Back-pressure once the next beat would pass the limit
    assign in_ready = en && (count_next <= {1'b0, limit});
    assign fire = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (clear) begin
            // Clear wins over a beat in the same cycle
            count <= '0;
        end else if (fire) begin
            count <= count_next[63:0];
        end
    end

    assign bits = count;

endmodule

`default_nettype wire

//--- rr_csrs.sv
`default_nettype none

module rr_csrs (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire rr_pkg::rr_axil_req_t     cfg_req,
    output rr_pkg::rr_axil_rsp_t          cfg_rsp,
    output rr_pkg::rr_storage_csr_t       storage_csr,
    output rr_pkg::rr_mode_csr_t          mode_csr,
    input  wire rr_pkg::rr_counter_csr_t  counter_csr
);

    logic [rr_pkg::rr_axil_data_width-1:0] csrs [rr_pkg::rr_csr_cnt];

    logic rst_done;

    // Write address and data channels
    logic aw_fire;
    logic w_fire;
    logic write_fire;
    logic aw_taken;
    logic w_taken;
    logic [rr_pkg::rr_csr_addr_width-1:0] wr_addr;
    logic [rr_pkg::rr_axil_data_width-1:0] wr_data;
    logic [rr_pkg::rr_axil_data_width-1:0] wr_mask;
    logic [rr_pkg::rr_axil_data_width-1:0] wr_merged;
    logic wr_storable;
    logic wr_q;
    logic wr_qq;

    // Write response
    logic bvalid;
    logic b_fire;
    logic b_busy;

    // Read channels
    logic arready;
    logic ar_fire;
    logic rvalid;
    logic r_fire;
    logic r_busy;
    logic [rr_pkg::rr_csr_addr_width-1:0] rd_addr;
    logic [rr_pkg::rr_axil_data_width-1:0] rdata;

    // Held low until the first cycle after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rst_done <= 1'b0;
        end else begin
            rst_done <= 1'b1;
        end
    end

    assign aw_fire = cfg_req.awvalid & cfg_rsp.awready;
    assign w_fire = cfg_req.wvalid & cfg_rsp.wready;
    assign write_fire = (aw_fire | aw_taken) & (w_fire | w_taken);

    assign b_fire = bvalid & cfg_req.bready;
    assign b_busy = bvalid & ~cfg_req.bready;

    // A taken channel waits for its partner
    always_ff @(posedge clk) begin
        if (!rstn) begin
            aw_taken <= 1'b0;
            w_taken <= 1'b0;
        end else begin
            if (write_fire) begin
                aw_taken <= 1'b0;
                w_taken <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_taken <= 1'b1;
                end
                if (w_fire) begin
                    w_taken <= 1'b1;
                end
            end
        end
    end

    // Address, data and byte mask capture
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr <= cfg_req.awaddr[2 +: rr_pkg::rr_csr_addr_width];
        end
        if (w_fire) begin
            wr_data <= cfg_req.wdata;
            for (int i = 0; i < rr_pkg::rr_axil_strb_width; i++) begin
                wr_mask[8*i +: 8] <= {8{cfg_req.wstrb[i]}};
            end
        end
    end

    assign wr_merged = (wr_mask & wr_data) | (~wr_mask & csrs[wr_addr]);

    // Commands and counter mirrors are never stored from the bus
    assign wr_storable = !(wr_addr inside {rr_pkg::record_buf_update,
                                           rr_pkg::validate_buf_update,
                                           rr_pkg::record_bits_lo,
                                           rr_pkg::record_bits_hi,
                                           rr_pkg::validate_bits_lo,
                                           rr_pkg::validate_bits_hi});

    // Merge and store one cycle after the write completes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_q <= 1'b0;
            wr_qq <= 1'b0;
            for (int i = 0; i < rr_pkg::rr_csr_cnt; i++) begin
                csrs[i] <= '0;
            end
        end else begin
            wr_q <= write_fire;
            wr_qq <= wr_q;
            if (wr_q && wr_storable) begin
                csrs[wr_addr] <= wr_merged;
            end
            // Meter counts, one cycle late
            csrs[rr_pkg::record_bits_lo] <= counter_csr.record_bits[31:0];
            csrs[rr_pkg::record_bits_hi] <= counter_csr.record_bits[63:32];
            csrs[rr_pkg::validate_bits_lo] <= counter_csr.validate_bits[31:0];
            csrs[rr_pkg::validate_bits_hi] <= counter_csr.validate_bits[63:32];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bvalid <= 1'b0;
        end else if (write_fire) begin
            bvalid <= 1'b1;
        end else if (b_fire) begin
            bvalid <= 1'b0;
        end
    end

    // Reads wait out any write between completion and store
    assign r_busy = rvalid & ~cfg_req.rready;
    assign r_fire = rvalid & cfg_req.rready;
    assign arready = rst_done & ~r_busy & ~(write_fire | wr_q | wr_qq);
    assign ar_fire = cfg_req.arvalid & arready;
    assign rd_addr = cfg_req.araddr[5:2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (r_fire) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= csrs[rd_addr];
        end
    end

    assign cfg_rsp = '{
        awready: rst_done & ~aw_taken & ~b_busy,
        wready:  rst_done & ~w_taken & ~b_busy,
        bvalid:  bvalid,
        bresp:   rr_pkg::rr_resp_okay,
        arready: arready,
        rvalid:  rvalid,
        rdata:   rdata,
        rresp:   rr_pkg::rr_resp_okay
    };

    assign storage_csr = '{
        buf_size:            {csrs[rr_pkg::buf_size_hi], csrs[rr_pkg::buf_size_lo]},
        record_buf_update:   wr_q && (wr_addr == rr_pkg::record_buf_update),
        validate_buf_update: wr_q && (wr_addr == rr_pkg::validate_buf_update)
    };

    assign mode_csr = '{
        record_en:   csrs[rr_pkg::rr_mode][0],
        validate_en: csrs[rr_pkg::rr_mode][1]
    };

endmodule

`default_nettype wire

//--- rr_pkg.sv
`default_nettype none

package rr_pkg;

    // Register file geometry
    localparam int unsigned rr_csr_cnt = 16;
    localparam int unsigned rr_csr_addr_width = 4;

    // Configuration bus widths
    localparam int unsigned rr_axil_addr_width = 32;
    localparam int unsigned rr_axil_data_width = 32;
    localparam int unsigned rr_axil_strb_width = rr_axil_data_width / 8;
    localparam int unsigned rr_counter_width = 64;

    localparam logic [1:0] rr_resp_okay = 2'b00;

    // Register index map, word addressed
    localparam logic [rr_csr_addr_width-1:0] rr_mode = 'd0;
    localparam logic [rr_csr_addr_width-1:0] buf_size_lo = 'd1;
    localparam logic [rr_csr_addr_width-1:0] buf_size_hi = 'd2;
    localparam logic [rr_csr_addr_width-1:0] record_buf_update = 'd3;
    localparam logic [rr_csr_addr_width-1:0] validate_buf_update = 'd4;
    localparam logic [rr_csr_addr_width-1:0] record_bits_lo = 'd5;
    localparam logic [rr_csr_addr_width-1:0] record_bits_hi = 'd6;
    localparam logic [rr_csr_addr_width-1:0] validate_bits_lo = 'd7;
    localparam logic [rr_csr_addr_width-1:0] validate_bits_hi = 'd8;

    // Master to slave
    typedef struct packed {
        logic                          awvalid;
        logic [rr_axil_addr_width-1:0] awaddr;
        logic                          wvalid;
        logic [rr_axil_data_width-1:0] wdata;
        logic [rr_axil_strb_width-1:0] wstrb;
        logic                          bready;
        logic                          arvalid;
        logic [rr_axil_addr_width-1:0] araddr;
        logic                          rready;
    } rr_axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                          awready;
        logic                          wready;
        logic                          bvalid;
        logic [1:0]                    bresp;
        logic                          arready;
        logic                          rvalid;
        logic [rr_axil_data_width-1:0] rdata;
        logic [1:0]                    rresp;
    } rr_axil_rsp_t;

    typedef struct packed {
        logic record_en;
        logic validate_en;
    } rr_mode_csr_t;

    // Update fields are single cycle pulses
    typedef struct packed {
        logic [rr_counter_width-1:0] buf_size;
        logic                        record_buf_update;
        logic                        validate_buf_update;
    } rr_storage_csr_t;

    typedef struct packed {
        logic [rr_counter_width-1:0] record_bits;
        logic [rr_counter_width-1:0] validate_bits;
    } rr_counter_csr_t;

    typedef struct packed {
        logic [15:0] tag;
        logic [31:0] value;
    } rr_record_beat_t;

    typedef struct packed {
        logic [31:0] value;
    } rr_validate_beat_t;

endpackage

`default_nettype wire
